// ==== design/pix_pkg.sv ====
`default_nettype none

package pix_pkg;

    // width of one color channel, luma uses the same width
    localparam int CHAN_W = 10;

    // width of the fixed point luma weights
    localparam int WGT_W = 7;

    // channel times weight before the shift
    localparam int PROD_W = CHAN_W + WGT_W;

    // unsaturated sum of the three weighted terms
    localparam int SUM_W = CHAN_W + 1;

    // luma saturates here
    localparam logic [CHAN_W-1:0] CHAN_MAX = 10'd1023;

    // weights as binary fractions: 19/64, 75/128 and 37/256
    localparam logic [WGT_W-1:0] W_RED   = 7'd19;
    localparam logic [WGT_W-1:0] W_GREEN = 7'd75;
    localparam logic [WGT_W-1:0] W_BLUE  = 7'd37;

    localparam int unsigned SH_RED   = 6;
    localparam int unsigned SH_GREEN = 7;
    localparam int unsigned SH_BLUE  = 8;

    // luma at or below this value maps to a black/white bit of 1
    localparam logic [CHAN_W-1:0] BW_THRESHOLD = 10'd512;

endpackage

`default_nettype wire

// ==== design/frame_pkg.sv ====
`default_nettype none

package frame_pkg;

    // one VGA frame, 640 x 480
    localparam int DEF_FRAME_PIXELS = 640 * 480;

    // wide enough to index every pixel of the default frame
    localparam int CNT_W = 20;

    // frame sequencer states
    typedef enum logic [1:0] {
        S_IDLE    = 2'd0,
        // read request goes out to the frame memory
        S_REQUEST = 2'd1,
        // one pixel accepted per cycle
        S_STREAM  = 2'd2
    } seq_state_e;

endpackage

`default_nettype wire

// ==== design/pixel_stream_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// sampled rgb pixels, sequencer to luma pipeline
interface pixel_stream_if;

    logic                        valid;
    // high together with the final valid of a frame
    logic                        last;
    logic [pix_pkg::CHAN_W-1:0]  red;
    logic [pix_pkg::CHAN_W-1:0]  green;
    logic [pix_pkg::CHAN_W-1:0]  blue;

    modport src (
        output valid,
        output last,
        output red,
        output green,
        output blue
    );

    modport snk (
        input valid,
        input last,
        input red,
        input green,
        input blue
    );

endinterface

`default_nettype wire

// ==== design/luma_stream_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// luma with the delayed rgb, luma pipeline to output stage
interface luma_stream_if;

    logic                        valid;
    logic                        last;
    logic [pix_pkg::CHAN_W-1:0]  luma;
    // original channels, aligned with luma
    logic [pix_pkg::CHAN_W-1:0]  red;
    logic [pix_pkg::CHAN_W-1:0]  green;
    logic [pix_pkg::CHAN_W-1:0]  blue;

    modport src (
        output valid,
        output last,
        output luma,
        output red,
        output green,
        output blue
    );

    modport snk (
        input valid,
        input last,
        input luma,
        input red,
        input green,
        input blue
    );

endinterface

`default_nettype wire

// ==== design/frame_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module frame_sequencer #(
    parameter int FRAME_PIXELS = frame_pkg::DEF_FRAME_PIXELS
) (
    input  wire logic                       i_clk,
    input  wire logic                       i_rst_n,
    input  wire logic                       i_start,
    input  wire logic [pix_pkg::CHAN_W-1:0] i_red,
    input  wire logic [pix_pkg::CHAN_W-1:0] i_green,
    input  wire logic [pix_pkg::CHAN_W-1:0] i_blue,
    output logic                            o_read_request,
    output logic                            o_vga_start,
    pixel_stream_if.src                     out
);

    frame_pkg::seq_state_e           state_q;
    logic [frame_pkg::CNT_W-1:0]     count_q;
    logic                            first_frame_q;
    logic                            read_req_q;
    logic                            vga_start_q;
    logic                            valid_q;
    logic                            last_q;
    logic [pix_pkg::CHAN_W-1:0]      red_q;
    logic [pix_pkg::CHAN_W-1:0]      green_q;
    logic [pix_pkg::CHAN_W-1:0]      blue_q;
    logic                            count_last;

    // counter sits on the final pixel of the frame
    assign count_last = (32'(count_q) == FRAME_PIXELS - 1);

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state_q       <= frame_pkg::S_IDLE;
            count_q       <= '0;
            first_frame_q <= 1'b1;
            read_req_q    <= 1'b0;
            vga_start_q   <= 1'b0;
            valid_q       <= 1'b0;
            last_q        <= 1'b0;
        end else begin
            // strobes default low, each lasts a single cycle
            read_req_q  <= 1'b0;
            vga_start_q <= 1'b0;
            valid_q     <= 1'b0;
            last_q      <= 1'b0;
            case (state_q)
                frame_pkg::S_IDLE: begin
                    if (i_start) begin
                        state_q     <= frame_pkg::S_REQUEST;
                        read_req_q  <= 1'b1;
                        vga_start_q <= first_frame_q;
                        count_q     <= '0;
                    end
                end
                frame_pkg::S_REQUEST: begin
                    // memory delivers the first pixel in the next cycle
                    state_q <= frame_pkg::S_STREAM;
                end
                frame_pkg::S_STREAM: begin
                    valid_q <= 1'b1;
                    count_q <= count_q + 1'b1;
                    if (count_last) begin
                        last_q        <= 1'b1;
                        first_frame_q <= 1'b0;
                        state_q       <= frame_pkg::S_IDLE;
                    end
                end
                default: begin
                    state_q <= frame_pkg::S_IDLE;
                end
            endcase
        end
    end

    // pixel capture, only meaningful alongside valid
    always_ff @(posedge i_clk) begin
        if (state_q == frame_pkg::S_STREAM) begin
            red_q   <= i_red;
            green_q <= i_green;
            blue_q  <= i_blue;
        end
    end

    assign o_read_request = read_req_q;
    assign o_vga_start    = vga_start_q;

    assign out.valid = valid_q;
    assign out.last  = last_q;
    assign out.red   = red_q;
    assign out.green = green_q;
    assign out.blue  = blue_q;

    a_single_request: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        o_read_request |=> !o_read_request
    );

    // outside streaming, valid only survives as the final pixel of the frame
    a_valid_from_stream: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        out.valid && !out.last |-> state_q == frame_pkg::S_STREAM
    );

endmodule

`default_nettype wire

// ==== design/luma_pipeline.sv ====
`timescale 1ns/1ps
`default_nettype none

module luma_pipeline (
    input  wire logic    i_clk,
    input  wire logic    i_rst_n,
    pixel_stream_if.snk  in,
    luma_stream_if.src   out
);

    logic [pix_pkg::PROD_W-1:0]  prod_red;
    logic [pix_pkg::PROD_W-1:0]  prod_green;
    logic [pix_pkg::PROD_W-1:0]  prod_blue;
    logic [pix_pkg::PROD_W-1:0]  shr_red;
    logic [pix_pkg::PROD_W-1:0]  shr_green;
    logic [pix_pkg::PROD_W-1:0]  shr_blue;

    // stage one registers
    logic                        s1_valid_q;
    logic                        s1_last_q;
    logic [pix_pkg::CHAN_W-1:0]  term_red_q;
    logic [pix_pkg::CHAN_W-1:0]  term_green_q;
    logic [pix_pkg::CHAN_W-1:0]  term_blue_q;
    logic [pix_pkg::CHAN_W-1:0]  s1_red_q;
    logic [pix_pkg::CHAN_W-1:0]  s1_green_q;
    logic [pix_pkg::CHAN_W-1:0]  s1_blue_q;

    // stage two registers
    logic [pix_pkg::SUM_W-1:0]   sum_w;
    logic                        s2_valid_q;
    logic                        s2_last_q;
    logic [pix_pkg::CHAN_W-1:0]  luma_q;
    logic [pix_pkg::CHAN_W-1:0]  s2_red_q;
    logic [pix_pkg::CHAN_W-1:0]  s2_green_q;
    logic [pix_pkg::CHAN_W-1:0]  s2_blue_q;

    // each channel is weighted and shifted on its own
    always_comb begin
        prod_red   = in.red * pix_pkg::W_RED;
        prod_green = in.green * pix_pkg::W_GREEN;
        prod_blue  = in.blue * pix_pkg::W_BLUE;
        shr_red    = prod_red >> pix_pkg::SH_RED;
        shr_green  = prod_green >> pix_pkg::SH_GREEN;
        shr_blue   = prod_blue >> pix_pkg::SH_BLUE;
    end

    // largest possible sum is 303 + 599 + 147, so one extra bit is enough
    assign sum_w = {1'b0, term_red_q} + {1'b0, term_green_q} + {1'b0, term_blue_q};

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            s1_valid_q <= 1'b0;
            s1_last_q  <= 1'b0;
            s2_valid_q <= 1'b0;
            s2_last_q  <= 1'b0;
        end else begin
            s1_valid_q <= in.valid;
            s1_last_q  <= in.last;
            s2_valid_q <= s1_valid_q;
            s2_last_q  <= s1_last_q;
        end
    end

    always_ff @(posedge i_clk) begin
        term_red_q   <= shr_red[pix_pkg::CHAN_W-1:0];
        term_green_q <= shr_green[pix_pkg::CHAN_W-1:0];
        term_blue_q  <= shr_blue[pix_pkg::CHAN_W-1:0];
        s1_red_q     <= in.red;
        s1_green_q   <= in.green;
        s1_blue_q    <= in.blue;
        // clamp to the channel range
        if (sum_w > {1'b0, pix_pkg::CHAN_MAX}) begin
            luma_q <= pix_pkg::CHAN_MAX;
        end else begin
            luma_q <= sum_w[pix_pkg::CHAN_W-1:0];
        end
        s2_red_q   <= s1_red_q;
        s2_green_q <= s1_green_q;
        s2_blue_q  <= s1_blue_q;
    end

    assign out.valid = s2_valid_q;
    assign out.last  = s2_last_q;
    assign out.luma  = luma_q;
    assign out.red   = s2_red_q;
    assign out.green = s2_green_q;
    assign out.blue  = s2_blue_q;

    // a saturated sum never wraps below any of its own terms
    a_luma_saturated: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        out.valid |-> out.luma >= $past(term_red_q)
            && out.luma >= $past(term_green_q)
            && out.luma >= $past(term_blue_q)
    );

endmodule

`default_nettype wire

// ==== design/gray_output.sv ====
`timescale 1ns/1ps
`default_nettype none

module gray_output (
    input  wire logic                  i_clk,
    input  wire logic                  i_rst_n,
    luma_stream_if.snk                 in,
    output logic                       o_valid,
    output logic                       o_last,
    output logic                       o_bw,
    output logic [pix_pkg::CHAN_W-1:0] o_gray,
    output logic [pix_pkg::CHAN_W-1:0] o_red,
    output logic [pix_pkg::CHAN_W-1:0] o_green,
    output logic [pix_pkg::CHAN_W-1:0] o_blue
);

    logic is_dark;

    // dark pixels, including the threshold itself, become 1
    assign is_dark = (in.luma <= pix_pkg::BW_THRESHOLD);

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_valid <= 1'b0;
            o_last  <= 1'b0;
            o_bw    <= 1'b0;
            o_gray  <= '0;
            o_red   <= '0;
            o_green <= '0;
            o_blue  <= '0;
        end else begin
            o_valid <= in.valid;
            o_last  <= in.last;
            // data holds its last value between frames
            if (in.valid) begin
                o_bw    <= is_dark;
                o_gray  <= in.luma;
                o_red   <= in.red;
                o_green <= in.green;
                o_blue  <= in.blue;
            end
        end
    end

    a_last_with_valid: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        o_last |-> o_valid
    );

endmodule

`default_nettype wire

// ==== design/grayscale_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module grayscale_top #(
    parameter int FRAME_PIXELS = frame_pkg::DEF_FRAME_PIXELS
) (
    input  wire logic                       i_clk,
    input  wire logic                       i_rst_n,
    input  wire logic                       i_start,
    // pixel stream from the frame memory
    input  wire logic [pix_pkg::CHAN_W-1:0] i_red,
    input  wire logic [pix_pkg::CHAN_W-1:0] i_green,
    input  wire logic [pix_pkg::CHAN_W-1:0] i_blue,
    output logic                            o_read_request,
    output logic                            o_vga_start,
    // processed pixels toward the display side
    output logic                            o_valid,
    output logic                            o_last,
    output logic [pix_pkg::CHAN_W-1:0]      o_gray,
    output logic                            o_bw,
    output logic [pix_pkg::CHAN_W-1:0]      o_red,
    output logic [pix_pkg::CHAN_W-1:0]      o_green,
    output logic [pix_pkg::CHAN_W-1:0]      o_blue
);

    pixel_stream_if pix_if ();
    luma_stream_if  luma_if ();

    // decode: frame sequencing and pixel capture
    frame_sequencer #(
        .FRAME_PIXELS (FRAME_PIXELS)
    ) u_decode (
        .i_clk          (i_clk),
        .i_rst_n        (i_rst_n),
        .i_start        (i_start),
        .i_red          (i_red),
        .i_green        (i_green),
        .i_blue         (i_blue),
        .o_read_request (o_read_request),
        .o_vga_start    (o_vga_start),
        .out            (pix_if.src)
    );

    // execute: two stage luma computation
    luma_pipeline u_execute (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .in      (pix_if.snk),
        .out     (luma_if.src)
    );

    // result: threshold and output registers
    gray_output u_result (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .in      (luma_if.snk),
        .o_valid (o_valid),
        .o_last  (o_last),
        .o_bw    (o_bw),
        .o_gray  (o_gray),
        .o_red   (o_red),
        .o_green (o_green),
        .o_blue  (o_blue)
    );

endmodule

`default_nettype wire

// ==== verification/grayscale_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module grayscale_tb;

    localparam int FRAME_PIXELS = 16;
    localparam int NUM_FRAMES   = 3;
    localparam int TOTAL_ROWS   = FRAME_PIXELS * NUM_FRAMES;
    localparam int CLK_PERIOD   = 4;
    // each frame gets its pixels plus a margin for request, pipeline and gaps
    localparam int TIMEOUT_NS   = NUM_FRAMES * (FRAME_PIXELS + 20) * CLK_PERIOD;
    localparam int CW           = pix_pkg::CHAN_W;

    // corner rows: black, white (clamps), then luma 511, 512 and 513
    localparam logic [CW-1:0] CORNER_RED   [5] = '{10'd0, 10'd1023, 10'd500, 10'd500, 10'd500};
    localparam logic [CW-1:0] CORNER_GREEN [5] = '{10'd0, 10'd1023, 10'd500, 10'd500, 10'd500};
    localparam logic [CW-1:0] CORNER_BLUE  [5] = '{10'd0, 10'd1023, 10'd493, 10'd500, 10'd506};

    logic          i_clk;
    logic          i_rst_n;
    logic          i_start;
    logic [CW-1:0] i_red;
    logic [CW-1:0] i_green;
    logic [CW-1:0] i_blue;
    logic          o_read_request;
    logic          o_vga_start;
    logic          o_valid;
    logic          o_last;
    logic [CW-1:0] o_gray;
    logic          o_bw;
    logic [CW-1:0] o_red;
    logic [CW-1:0] o_green;
    logic [CW-1:0] o_blue;

    // stimulus and expected values, one row per pixel
    logic [CW-1:0] tbl_red   [TOTAL_ROWS];
    logic [CW-1:0] tbl_green [TOTAL_ROWS];
    logic [CW-1:0] tbl_blue  [TOTAL_ROWS];
    logic [CW-1:0] tbl_gray  [TOTAL_ROWS];
    logic          tbl_bw    [TOTAL_ROWS];

    int   data_errors;
    int   ctrl_errors;
    int   out_count;
    int   req_count;
    int   vga_count;
    logic req_prev;

    grayscale_top #(
        .FRAME_PIXELS (FRAME_PIXELS)
    ) UUT (
        .i_clk          (i_clk),
        .i_rst_n        (i_rst_n),
        .i_start        (i_start),
        .i_red          (i_red),
        .i_green        (i_green),
        .i_blue         (i_blue),
        .o_read_request (o_read_request),
        .o_vga_start    (o_vga_start),
        .o_valid        (o_valid),
        .o_last         (o_last),
        .o_gray         (o_gray),
        .o_bw           (o_bw),
        .o_red          (o_red),
        .o_green        (o_green),
        .o_blue         (o_blue)
    );

    initial begin
        i_clk = 1'b0;
        forever #(CLK_PERIOD / 2) i_clk = ~i_clk;
    end

    // weighted sum with each term truncated on its own, then clamped
    function automatic logic [CW-1:0] expected_luma(input logic [CW-1:0] r,
                                                    input logic [CW-1:0] g,
                                                    input logic [CW-1:0] b);
        int sum;
        sum = ((int'(r) * int'(pix_pkg::W_RED)) >> pix_pkg::SH_RED)
            + ((int'(g) * int'(pix_pkg::W_GREEN)) >> pix_pkg::SH_GREEN)
            + ((int'(b) * int'(pix_pkg::W_BLUE)) >> pix_pkg::SH_BLUE);
        if (sum > int'(pix_pkg::CHAN_MAX)) begin
            sum = int'(pix_pkg::CHAN_MAX);
        end
        return sum[CW-1:0];
    endfunction

    task automatic build_table();
        int idx;
        for (idx = 0; idx < TOTAL_ROWS; idx++) begin
            tbl_red[idx]   = CW'($urandom);
            tbl_green[idx] = CW'($urandom);
            tbl_blue[idx]  = CW'($urandom);
        end
        // corners open the first frame and close the last one
        for (idx = 0; idx < 5; idx++) begin
            tbl_red[idx]                  = CORNER_RED[idx];
            tbl_green[idx]                = CORNER_GREEN[idx];
            tbl_blue[idx]                 = CORNER_BLUE[idx];
            tbl_red[TOTAL_ROWS - 5 + idx]   = CORNER_RED[idx];
            tbl_green[TOTAL_ROWS - 5 + idx] = CORNER_GREEN[idx];
            tbl_blue[TOTAL_ROWS - 5 + idx]  = CORNER_BLUE[idx];
        end
        for (idx = 0; idx < TOTAL_ROWS; idx++) begin
            tbl_gray[idx] = expected_luma(tbl_red[idx], tbl_green[idx], tbl_blue[idx]);
            tbl_bw[idx]   = (tbl_gray[idx] <= pix_pkg::BW_THRESHOLD);
        end
    endtask

    task automatic compare_field(input string name, input int row,
                                 input logic [15:0] expected, input logic [15:0] actual);
        if (actual !== expected) begin
            $display("FAILED %s row %0d: expected %h, got %h", name, row, expected, actual);
            data_errors++;
        end
    endtask

    task automatic check_reset_state();
        if (o_read_request || o_vga_start || o_valid || o_last || o_bw
            || o_gray != '0 || o_red != '0 || o_green != '0 || o_blue != '0) begin
            $display("outputs are not all zero while reset is held");
            ctrl_errors++;
        end
    endtask

    // request and vga start strobes
    always @(negedge i_clk) begin
        if (i_rst_n) begin
            if (o_read_request && req_prev) begin
                $display("read request stayed high for two cycles at %0t", $time);
                ctrl_errors++;
            end
            if (o_vga_start) begin
                if (!o_read_request || req_count != 0) begin
                    $display("VGA start pulsed outside the first frame request at %0t", $time);
                    ctrl_errors++;
                end
                vga_count++;
            end
            if (o_read_request) begin
                req_count++;
            end
            req_prev = o_read_request;
        end
    end

    // output pixels, compared in order against the table
    always @(negedge i_clk) begin
        if (i_rst_n) begin
            if (o_last && !o_valid) begin
                $display("last marker without valid at %0t", $time);
                ctrl_errors++;
            end
            if (o_valid) begin
                if (out_count >= TOTAL_ROWS) begin
                    $display("extra valid output beyond %0d pixels at %0t", TOTAL_ROWS, $time);
                    ctrl_errors++;
                end else begin
                    compare_field("o_gray", out_count, 16'(tbl_gray[out_count]), 16'(o_gray));
                    compare_field("o_bw", out_count, 16'(tbl_bw[out_count]), 16'(o_bw));
                    compare_field("o_red", out_count, 16'(tbl_red[out_count]), 16'(o_red));
                    compare_field("o_green", out_count, 16'(tbl_green[out_count]), 16'(o_green));
                    compare_field("o_blue", out_count, 16'(tbl_blue[out_count]), 16'(o_blue));
                    compare_field("o_last", out_count,
                                  16'((out_count % FRAME_PIXELS) == FRAME_PIXELS - 1),
                                  16'(o_last));
                end
                out_count++;
            end
        end
    end

    initial begin
        #(TIMEOUT_NS);
        $display("timeout: run did not finish within %0d ns", TIMEOUT_NS);
        $display("Simulation failed");
        $finish;
    end

    initial begin : stimulus
        int   f;
        int   r;
        int   w;
        int   base;
        logic seen;
        void'($urandom(93276));
        data_errors = 0;
        ctrl_errors = 0;
        out_count   = 0;
        req_count   = 0;
        vga_count   = 0;
        req_prev    = 1'b0;
        i_rst_n     = 1'b0;
        i_start     = 1'b0;
        i_red       = '0;
        i_green     = '0;
        i_blue      = '0;
        build_table();
        repeat (2) @(negedge i_clk);
        check_reset_state();
        i_rst_n = 1'b1;

        // memory model, one row per cycle once the request is seen
        for (f = 0; f < NUM_FRAMES; f++) begin
            @(negedge i_clk);
            i_start = 1'b1;
            seen    = 1'b0;
            w       = 0;
            while (!seen && w < 8) begin
                @(negedge i_clk);
                i_start = 1'b0;
                seen    = o_read_request;
                w++;
            end
            if (!seen) begin
                $display("no read request seen for frame %0d", f);
                ctrl_errors++;
            end
            base = f * FRAME_PIXELS;
            for (r = 0; r < FRAME_PIXELS; r++) begin
                @(negedge i_clk);
                i_red   = tbl_red[base + r];
                i_green = tbl_green[base + r];
                i_blue  = tbl_blue[base + r];
                // a start in the middle of the stream must be ignored
                i_start = (f == 1 && r == 5);
            end
        end

        while (out_count < TOTAL_ROWS) @(negedge i_clk);
        // idle time to catch stray requests or outputs
        repeat (10) @(negedge i_clk);
        if (req_count != NUM_FRAMES) begin
            $display("expected %0d read requests, saw %0d", NUM_FRAMES, req_count);
            ctrl_errors++;
        end
        if (vga_count != 1) begin
            $display("expected one VGA start pulse, saw %0d", vga_count);
            ctrl_errors++;
        end
        $display("errors: %0d data, %0d control", data_errors, ctrl_errors);
        if (data_errors + ctrl_errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
design/pix_pkg.sv
design/frame_pkg.sv
design/pixel_stream_if.sv
design/luma_stream_if.sv
design/frame_sequencer.sv
design/luma_pipeline.sv
design/gray_output.sv
design/grayscale_top.sv
verification/grayscale_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the grayscale converter testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=grayscale_sim

verilator --binary --timing --assert -Wno-fatal \
    -f vlog.f --top-module grayscale_tb -Mdir obj_dir -o "$BIN"
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/"$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

# the log decides pass or fail
if grep -q "Simulation failed" "$LOG"; then
    exit 1
fi
if ! grep -q "Simulation passed" "$LOG"; then
    echo "no result line found in $LOG"
    exit 1
fi
exit 0
